// File: frame_output_stage.f
rtl/stream_pkg.sv
rtl/buffer_pkg.sv
rtl/frame_collector.sv
rtl/dual_write_ram.sv
rtl/pingpong_store.sv
rtl/word_packer.sv
rtl/frame_output_stage.sv
testbench/tb_clock_gen.sv
testbench/tb_frame_output_stage.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_frame_output_stage
FILELIST  = frame_output_stage.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | awk '{ print } /Simulation passed/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJDIR)

// File: testbench/tb_frame_output_stage.sv
//##################################################
// Frame output stage testbench with random frames, reference
// packing, output compare, latency check and watchdog.
//##################################################
`default_nettype none

module tb_frame_output_stage;

    logic                          iClock;
    logic                          rst_n;
    logic                          enable;
    logic                          frame_done;
    stream_pkg::lane_pair_t        lanes;
    stream_pkg::out_word_t         out;

    integer                        seed;
    int                            error_count;
    int                            received;
    int                            total_sent;
    int                            carry;           // Word held over from the last frame.
    int                            watchdog_cycles = 0;
    int                            len_q[$];
    int                            exp_q[$];
    logic [stream_pkg::WORD_W-1:0] ref_q[$];
    logic                          armed;
    logic                          prev_en;
    logic                          expect_valid;
    int                            lat_edges;
    int                            outs_left;

    tb_clock_gen clock0 (
        .iClock (iClock),
        .rst_n  (rst_n)
    );

    frame_output_stage dut0 (
        .iClock     (iClock),
        .rst_n      (rst_n),
        .enable     (enable),
        .lanes      (lanes),
        .frame_done (frame_done),
        .out        (out)
    );

    function automatic int rand_range(input int lo, input int hi);
        int unsigned r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    function automatic logic [stream_pkg::WORD_W-1:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    // Pops the next two words sent and packs them, earlier word in the low half.
    function automatic logic [stream_pkg::OUT_W-1:0] expected_word();
        logic [stream_pkg::WORD_W-1:0] first;
        logic [stream_pkg::WORD_W-1:0] second;
        first  = ref_q.pop_front();
        second = ref_q.pop_front();
        return {second[7:0], second[15:8], first[7:0], first[15:8]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s got %h expected %h at time %0t", name, got, exp, $time);
        end
    endtask

    task automatic drive_idle(input logic en, input logic done);
        @(posedge iClock);
        enable     <= en;
        lanes      <= '0;
        frame_done <= done;
    endtask

    task automatic stall_random();
        int n;
        n = (rand_range(0, 3) == 0) ? rand_range(1, 3) : 0;
        repeat (n) drive_idle(1'b0, 1'b0);
    endtask

    task automatic send_frame(input int len, input bit mixed, input bit stalls);
        int                            sent;
        int                            n;
        int                            pending;
        logic [stream_pkg::WORD_W-1:0] w0;
        logic [stream_pkg::WORD_W-1:0] w1;
        sent = 0;
        while (sent < len) begin
            if (stalls) stall_random();
            n  = (len - sent >= 2 && (!mixed || rand_range(0, 1) == 1)) ? 2 : 1;
            w0 = rand_word();
            w1 = (n == 2) ? rand_word() : '0;
            @(posedge iClock);
            enable            <= 1'b1;
            frame_done        <= 1'b0;
            lanes.lane0.valid <= 1'b1;
            lanes.lane0.data  <= w0;
            lanes.lane1.valid <= (n == 2);
            lanes.lane1.data  <= w1;
            ref_q.push_back(w0);
            if (n == 2) ref_q.push_back(w1);
            sent += n;
        end
        pending = carry + len;
        exp_q.push_back(pending / 2);
        carry = pending % 2;
        total_sent += len;
        drive_idle(1'b1, 1'b1);
        // Spacing counts enabled cycles only.
        repeat ((len + 1) / 2 + 3) begin
            if (stalls) stall_random();
            drive_idle(1'b1, 1'b0);
        end
    endtask

    task automatic wait_drain();
        while (armed) @(posedge iClock);
        repeat (2) @(posedge iClock);
    endtask

    task automatic run_test(input string name, input int frames, input bit mixed,
                            input bit stalls);
        int start_errors;
        start_errors = error_count;
        repeat (frames) send_frame(len_q.pop_front(), mixed, stalls);
        wait_drain();
        $display("Test %-14s frames %0d errors %0d", name, frames, error_count - start_errors);
    endtask

    // Sampled on the falling edge, half a cycle after the inputs and registers move.
    always @(negedge iClock) begin
        if (armed && prev_en) lat_edges++;
        expect_valid = armed && enable && lat_edges >= 3 && outs_left > 0;
        check_value("out.valid", 32'(out.valid), 32'(expect_valid));
        if (out.valid) begin
            received++;
            if (ref_q.size() < 2) begin
                error_count++;
                $display("Output word %0d arrived with no words left to pair", received);
            end else begin
                check_value("out.data", out.data, expected_word());
            end
            if (outs_left > 0) outs_left--;
            if (outs_left == 0) armed = 1'b0;
        end
        if (enable && frame_done) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("Frame end seen with no frame queued by the driver");
            end else begin
                outs_left = exp_q.pop_front();
            end
            armed     = (outs_left > 0);
            lat_edges = 0;
        end
        prev_en = enable;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge iClock);
        $display("Timeout after %0d cycles, the frames never finished", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int sum_len;
        seed        = 12;
        error_count = 0;
        received    = 0;
        total_sent  = 0;
        carry       = 0;
        armed       = 1'b0;
        prev_en     = 1'b0;
        lat_edges   = 0;
        outs_left   = 0;
        enable      = 1'b0;
        frame_done  = 1'b0;
        lanes       = '0;
        repeat (4) len_q.push_back(rand_range(1, 40) * 2);
        repeat (4) len_q.push_back(rand_range(0, 40) * 2 + 1);
        len_q.push_back(1);
        len_q.push_back(256);
        repeat (3) len_q.push_back(rand_range(1, 60));
        repeat (3) len_q.push_back(rand_range(1, 30));
        repeat (4) len_q.push_back(rand_range(1, 80));
        sum_len = 0;
        foreach (len_q[i]) sum_len += len_q[i];
        // Each word costs at most about three cycles with stalls and spacing.
        watchdog_cycles = 3 * sum_len + 40 * len_q.size() + 40;

        drive_idle(1'b1, 1'b0);
        wait (rst_n === 1'b1);
        repeat (4) drive_idle(1'b1, 1'b0);
        $display("Test %-14s frames 0 errors %0d", "reset", error_count);

        run_test("even frames", 4, 1'b0, 1'b0);
        run_test("odd frames", 4, 1'b0, 1'b0);
        run_test("mixed lanes", 5, 1'b1, 1'b0);
        run_test("latency", 3, 1'b1, 1'b0);
        run_test("enable stalls", 4, 1'b1, 1'b1);

        if (received != total_sent / 2) begin
            error_count++;
            $display("Received %0d output words but %0d words sent should give %0d",
                     received, total_sent, total_sent / 2);
        end
        $display("Done with %0d words sent, %0d output words, %0d errors",
                 total_sent, received, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
//##################################################
// Testbench clock and synchronous reset source.
//##################################################
`default_nettype none

module tb_clock_gen (
    output logic iClock,
    output logic rst_n
);

    initial begin
        iClock = 1'b0;
        forever #2 iClock = ~iClock;    // Period of 4.
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge iClock);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: rtl/frame_output_stage.sv
//##################################################
// Output stage top: collector, ping-pong store, packer.
//##################################################
`default_nettype none

module frame_output_stage (
    input  logic                   iClock,
    input  logic                   rst_n,
    input  logic                   enable,
    input  stream_pkg::lane_pair_t lanes,
    input  logic                   frame_done,
    output stream_pkg::out_word_t  out
);

    buffer_pkg::write_req_t        write_req;
    buffer_pkg::read_req_t         read_req;
    buffer_pkg::len_t              frame_len;
    logic                          swap;
    logic [stream_pkg::WORD_W-1:0] rd_data0;
    logic [stream_pkg::WORD_W-1:0] rd_data1;

    frame_collector collector0 (
        .iClock     (iClock),
        .rst_n      (rst_n),
        .enable     (enable),
        .lanes      (lanes),
        .frame_done (frame_done),
        .write_req  (write_req),
        .swap       (swap),
        .frame_len  (frame_len)
    );

    pingpong_store store0 (
        .iClock    (iClock),
        .rst_n     (rst_n),
        .enable    (enable),
        .swap      (swap),
        .write_req (write_req),
        .read_req  (read_req),
        .rd_data0  (rd_data0),
        .rd_data1  (rd_data1)
    );

    // The packer sees the same swap pulse as the store, one cycle after frame_done.
    word_packer packer0 (
        .iClock    (iClock),
        .rst_n     (rst_n),
        .enable    (enable),
        .swap      (swap),
        .frame_len (frame_len),
        .rd_data0  (rd_data0),
        .rd_data1  (rd_data1),
        .read_req  (read_req),
        .out       (out)
    );

endmodule

`default_nettype wire

// File: rtl/word_packer.sv
//##################################################
// Output side: frame readout, half-word carry and packing.
//##################################################
`default_nettype none

module word_packer (
    input  logic                          iClock,
    input  logic                          rst_n,
    input  logic                          enable,
    input  logic                          swap,
    input  buffer_pkg::len_t              frame_len,
    input  logic [stream_pkg::WORD_W-1:0] rd_data0,
    input  logic [stream_pkg::WORD_W-1:0] rd_data1,
    output buffer_pkg::read_req_t         read_req,
    output stream_pkg::out_word_t         out
);

    buffer_pkg::reader_state_e     state;
    buffer_pkg::len_t              total;
    buffer_pkg::len_t              reads_left;
    buffer_pkg::addr_t             next_addr;
    buffer_pkg::read_req_t         issue_req;
    buffer_pkg::read_req_t         held_req;
    logic                          odd_frame;
    logic                          first_carry;
    logic                          last_read;
    logic                          d_valid;
    logic                          d_use_carry;
    logic                          d_keep;
    logic                          carry_valid;
    logic [stream_pkg::WORD_W-1:0] carry_word;
    logic [stream_pkg::WORD_W-1:0] lower_word;
    logic [stream_pkg::WORD_W-1:0] upper_word;

    function automatic logic [stream_pkg::WORD_W-1:0] byte_swap(
        input logic [stream_pkg::WORD_W-1:0] w
    );
        return {w[7:0], w[15:8]};
    endfunction

    assign total     = frame_len + buffer_pkg::len_t'(carry_valid);
    assign last_read = (reads_left == buffer_pkg::len_t'(1));

    // Each read cycle consumes two words, the first one counting the carry.
    always_ff @(posedge iClock) begin
        if (!rst_n) begin
            state       <= buffer_pkg::IDLE;
            reads_left  <= '0;
            first_carry <= 1'b0;
            d_valid     <= 1'b0;
            d_use_carry <= 1'b0;
            d_keep      <= 1'b0;
        end else if (enable) begin
            d_valid     <= 1'b0;
            d_use_carry <= 1'b0;
            d_keep      <= 1'b0;
            case (state)
                buffer_pkg::IDLE: begin
                    if (swap) begin
                        state       <= buffer_pkg::READ;
                        reads_left  <= (total + 1'b1) >> 1;
                        first_carry <= carry_valid;
                    end
                end
                buffer_pkg::READ: begin
                    d_valid     <= !(last_read && odd_frame);
                    d_use_carry <= first_carry;
                    d_keep      <= last_read && odd_frame;    // Odd tail becomes the next carry.
                    first_carry <= 1'b0;
                    reads_left  <= reads_left - 1'b1;
                    if (last_read) begin
                        state <= buffer_pkg::IDLE;
                    end
                end
                default: state <= buffer_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge iClock) begin
        if (enable) begin
            held_req <= issue_req;
            if (state == buffer_pkg::IDLE && swap) begin
                odd_frame       <= total[0];
                issue_req.addr0 <= '0;
                issue_req.addr1 <= buffer_pkg::addr_t'(1);
                next_addr       <= carry_valid ? buffer_pkg::addr_t'(1) : buffer_pkg::addr_t'(2);
            end else if (state == buffer_pkg::READ) begin
                issue_req.addr0 <= next_addr;
                issue_req.addr1 <= next_addr + 1'b1;
                next_addr       <= next_addr + 2'd2;
            end
        end
    end

    // While stalled the banks re-read the previous address, so read data stays put.
    assign read_req = enable ? issue_req : held_req;

    always_ff @(posedge iClock) begin
        if (!rst_n) begin
            carry_valid <= 1'b0;
        end else if (enable) begin
            if (d_keep) begin
                carry_valid <= 1'b1;
            end else if (d_use_carry) begin
                carry_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (enable && d_keep) begin
            carry_word <= rd_data0;
        end
    end

    assign lower_word = d_use_carry ? carry_word : rd_data0;
    assign upper_word = d_use_carry ? rd_data0 : rd_data1;

    assign out.valid = d_valid && enable;
    assign out.data  = {byte_swap(upper_word), byte_swap(lower_word)};

    // Frame spacing upstream guarantees the previous readout has finished.
    swap_idle_a: assert property (@(posedge iClock) disable iff (!rst_n)
        enable && swap |-> state == buffer_pkg::IDLE);

endmodule

`default_nettype wire

// File: rtl/pingpong_store.sv
//##################################################
// Ping-pong frame store with bank steering.
//##################################################
`default_nettype none

module pingpong_store (
    input  logic                          iClock,
    input  logic                          rst_n,
    input  logic                          enable,
    input  logic                          swap,
    input  buffer_pkg::write_req_t        write_req,
    input  buffer_pkg::read_req_t         read_req,
    output logic [stream_pkg::WORD_W-1:0] rd_data0,
    output logic [stream_pkg::WORD_W-1:0] rd_data1
);

    logic                          bank_sel;
    logic                          wr_sel;
    buffer_pkg::write_req_t        bank0_wr;
    buffer_pkg::write_req_t        bank1_wr;
    logic [stream_pkg::WORD_W-1:0] bank0_rd0;
    logic [stream_pkg::WORD_W-1:0] bank0_rd1;
    logic [stream_pkg::WORD_W-1:0] bank1_rd0;
    logic [stream_pkg::WORD_W-1:0] bank1_rd1;

    // The first words of a new frame may arrive in the swap cycle itself.
    assign wr_sel = bank_sel ^ swap;

    always_comb begin
        bank0_wr = write_req;
        bank1_wr = write_req;
        if (wr_sel) begin
            bank0_wr.port0.en = 1'b0;
            bank0_wr.port1.en = 1'b0;
        end else begin
            bank1_wr.port0.en = 1'b0;
            bank1_wr.port1.en = 1'b0;
        end
    end

    always_ff @(posedge iClock) begin
        if (!rst_n) begin
            bank_sel <= 1'b0;
        end else if (enable && swap) begin
            bank_sel <= ~bank_sel;
        end
    end

    dual_write_ram bank0 (
        .iClock    (iClock),
        .write_req (bank0_wr),
        .read_req  (read_req),
        .rd_data0  (bank0_rd0),
        .rd_data1  (bank0_rd1)
    );

    dual_write_ram bank1 (
        .iClock    (iClock),
        .write_req (bank1_wr),
        .read_req  (read_req),
        .rd_data0  (bank1_rd0),
        .rd_data1  (bank1_rd1)
    );

    assign rd_data0 = bank_sel ? bank0_rd0 : bank1_rd0;    // Read the bank not being filled.
    assign rd_data1 = bank_sel ? bank0_rd1 : bank1_rd1;

endmodule

`default_nettype wire

// File: rtl/dual_write_ram.sv
//##################################################
// One frame bank with two write and two read ports.
//##################################################
`default_nettype none

module dual_write_ram (
    input  logic                          iClock,
    input  buffer_pkg::write_req_t        write_req,
    input  buffer_pkg::read_req_t         read_req,
    output logic [stream_pkg::WORD_W-1:0] rd_data0,
    output logic [stream_pkg::WORD_W-1:0] rd_data1
);

    logic [stream_pkg::WORD_W-1:0] mem [buffer_pkg::DEPTH];

    always_ff @(posedge iClock) begin
        if (write_req.port0.en) begin
            mem[write_req.port0.addr] <= write_req.port0.data;
        end
        if (write_req.port1.en) begin
            mem[write_req.port1.addr] <= write_req.port1.data;
        end
    end

    always_ff @(posedge iClock) begin
        rd_data0 <= mem[read_req.addr0];
        rd_data1 <= mem[read_req.addr1];
    end

    // The collector numbers words consecutively, so both ports never hit one entry.
    distinct_wr_a: assert property (@(posedge iClock)
        write_req.port0.en && write_req.port1.en
            |-> write_req.port0.addr != write_req.port1.addr);

endmodule

`default_nettype wire

// File: rtl/frame_collector.sv
//##################################################
// Input side: frame addressing and length capture.
//##################################################
`default_nettype none

module frame_collector (
    input  logic                   iClock,
    input  logic                   rst_n,
    input  logic                   enable,
    input  stream_pkg::lane_pair_t lanes,
    input  logic                   frame_done,
    output buffer_pkg::write_req_t write_req,
    output logic                   swap,
    output buffer_pkg::len_t       frame_len
);

    buffer_pkg::len_t count;
    buffer_pkg::len_t lane_count;

    assign lane_count = buffer_pkg::len_t'(lanes.lane0.valid)
                      + buffer_pkg::len_t'(lanes.lane1.valid);

    // Words go straight to the store in the cycle they arrive.
    always_comb begin
        write_req.port0.en   = enable && lanes.lane0.valid;
        write_req.port0.addr = count[buffer_pkg::ADDR_W-1:0];
        write_req.port0.data = lanes.lane0.data;
        write_req.port1.en   = enable && lanes.lane1.valid;
        write_req.port1.addr = count[buffer_pkg::ADDR_W-1:0] + 1'b1;
        write_req.port1.data = lanes.lane1.data;
    end

    always_ff @(posedge iClock) begin
        if (!rst_n) begin
            count <= '0;
            swap  <= 1'b0;
        end else if (enable) begin
            swap <= frame_done;
            if (frame_done) begin
                count <= '0;
            end else begin
                count <= count + lane_count;
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (enable && frame_done) begin
            frame_len <= count;    // Count already equals the number of words in the frame.
        end
    end

    lane_order_a: assert property (@(posedge iClock) disable iff (!rst_n)
        lanes.lane1.valid |-> lanes.lane0.valid);

    // The upstream stage closes a frame only on an idle cycle.
    done_idle_a: assert property (@(posedge iClock) disable iff (!rst_n)
        frame_done |-> !lanes.lane0.valid && !lanes.lane1.valid);

endmodule

`default_nettype wire

// File: rtl/buffer_pkg.sv
//##################################################
// Frame buffer sizes, port structs and reader states.
//##################################################
`default_nettype none

package buffer_pkg;

    localparam int ADDR_W = 8;
    localparam int DEPTH  = 1 << ADDR_W;

    typedef logic [ADDR_W:0]   len_t;    // One extra bit so a full bank of 256 fits.
    typedef logic [ADDR_W-1:0] addr_t;

    typedef struct packed {
        logic                          en;
        addr_t                         addr;
        logic [stream_pkg::WORD_W-1:0] data;
    } wr_port_t;

    typedef struct packed {
        wr_port_t port1;
        wr_port_t port0;
    } write_req_t;

    typedef struct packed {
        addr_t addr1;
        addr_t addr0;
    } read_req_t;

    typedef enum logic {IDLE = 1'b0, READ = 1'b1} reader_state_e;

endpackage

`default_nettype wire

// File: rtl/stream_pkg.sv
//##################################################
// Stream widths, the input lane pair and the output word.
//##################################################
`default_nettype none

package stream_pkg;

    localparam int WORD_W = 16;
    localparam int OUT_W  = 32;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] data;
    } lane_t;

    // Lane 0 always holds the earlier of the two words.
    typedef struct packed {
        lane_t lane1;
        lane_t lane0;
    } lane_pair_t;

    typedef struct packed {
        logic             valid;
        logic [OUT_W-1:0] data;
    } out_word_t;

endpackage

`default_nettype wire
